/* hw/cpu_pkg.sv */
// cpu package: operation and exception enums plus the pipeline stage records
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [3:0]
    {
        NOP,
        ADD,
        SUB,
        AND,
        OR,
        SLT,
        ADDI,
        LW,
        SW
    } op_t;

    typedef enum logic [1:0]
    {
        NONE,
        UNDEFINED,   // raised in decode
        OVERFLOW     // raised in execute
    } exc_cause_t;

    typedef struct packed
    {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instr;
    } if_id_t;

    typedef struct packed
    {
        logic                   valid;
        op_t                    op;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs_val;
        logic [`XLEN-1:0]       rt_val;
        logic [`XLEN-1:0]       imm;        // already sign-extended
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writes_reg;
        exc_cause_t             exc;
    } id_ex_t;

    typedef struct packed
    {
        logic                   valid;
        op_t                    op;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       result;     // alu result or memory address
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writes_reg;
        exc_cause_t             exc;
    } ex_mem_t;

    typedef struct packed
    {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       result;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   writes_reg;
        exc_cause_t             exc;
    } mem_wb_t;

endpackage

/* hw/cpu_settings.svh */
// cpu settings: widths, MIPS opcode and funct encodings, reset PC, vector and memory depth
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define XLEN        32
`define REG_ADDR_W  5

`define RESET_PC    32'h0040_0000   // first fetch after reset
`define EXC_VECTOR  32'h8000_0180   // exception handler entry
`define DMEM_WORDS  64

`define OPC_RTYPE   6'h00
`define OPC_ADDI    6'h08
`define OPC_LW      6'h23
`define OPC_SW      6'h2b

`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`endif

/* hw/cpu_top.sv */
// cpu top: five-stage MIPS pipeline with external instruction memory
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top
(
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    output logic [`XLEN-1:0]        imem_addr,
    input  logic [`XLEN-1:0]        imem_data,
    output logic                    commit_valid,
    output logic [`REG_ADDR_W-1:0]  commit_reg,
    output logic [`XLEN-1:0]        commit_data,
    output logic                    exc_valid,
    output cpu_pkg::exc_cause_t     exc_cause,
    output logic [`XLEN-1:0]        epc
);

    cpu_pkg::if_id_t        if_id;
    cpu_pkg::id_ex_t        id_ex_d;
    cpu_pkg::id_ex_t        id_ex_q;
    cpu_pkg::ex_mem_t       ex_mem_d;
    cpu_pkg::ex_mem_t       ex_mem_q;
    cpu_pkg::mem_wb_t       mem_wb_d;
    logic                   stall;
    logic                   flush;
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_reg;
    logic [`XLEN-1:0]       wb_data;

    fetch_stage fetch_stage_i
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .stall      (stall),
        .flush      (flush),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .if_id      (if_id)
    );

    decode_stage decode_stage_i
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .if_id      (if_id),
        .flush      (flush),
        .stall      (stall),
        .id_ex_q    (id_ex_q),      // hazard check against execute
        .ex_mem_q   (ex_mem_q),     // and against memory
        .wb_we      (wb_we),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .id_ex_d    (id_ex_d)
    );

    execute_stage execute_stage_i
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .flush      (flush),
        .id_ex_d    (id_ex_d),
        .id_ex_q    (id_ex_q),
        .ex_mem_d   (ex_mem_d)
    );

    memory_stage memory_stage_i
    (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .flush      (flush),
        .ex_mem_d   (ex_mem_d),
        .ex_mem_q   (ex_mem_q),
        .mem_wb_d   (mem_wb_d)
    );

    writeback_stage writeback_stage_i
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .mem_wb_d       (mem_wb_d),
        .flush          (flush),
        .wb_we          (wb_we),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .commit_valid   (commit_valid),
        .commit_reg     (commit_reg),
        .commit_data    (commit_data),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .epc            (epc)
    );

endmodule

/* hw/decode_stage.sv */
// decode stage: register file, instruction decode, undefined-opcode check and RAW stall
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage
(
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  cpu_pkg::if_id_t         if_id,
    input  logic                    flush,
    output logic                    stall,
    input  cpu_pkg::id_ex_t         id_ex_q,
    input  cpu_pkg::ex_mem_t        ex_mem_q,
    input  logic                    wb_we,
    input  logic [`REG_ADDR_W-1:0]  wb_reg,
    input  logic [`XLEN-1:0]        wb_data,
    output cpu_pkg::id_ex_t         id_ex_d
);

    logic [`XLEN-1:0]       regs [2**`REG_ADDR_W];
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reads_rs;
    logic                   reads_rt;
    cpu_pkg::id_ex_t        dec;

    assign opcode = if_id.instr[31:26];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign funct  = if_id.instr[5:0];

    always_ff @(posedge SYS_clk)
    begin
        if (wb_we && wb_reg != '0)
            regs[wb_reg] <= wb_data;
    end

    // r0 reads zero, a writeback in this cycle is seen at once
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_ADDR_W-1:0] r);
        if (r == '0)
            return '0;
        if (wb_we && wb_reg == r)
            return wb_data;
        return regs[r];
    endfunction

    // register still owed by an older instruction in execute or memory
    function automatic logic pending(input logic [`REG_ADDR_W-1:0] r);
        return r != '0 &&
               ((id_ex_q.valid && id_ex_q.writes_reg && id_ex_q.dest == r) ||
                (ex_mem_q.valid && ex_mem_q.writes_reg && ex_mem_q.dest == r));
    endfunction

    always_comb
    begin
        dec            = '0;
        dec.valid      = if_id.valid;
        dec.pc         = if_id.pc;
        dec.rs_val     = read_reg(rs);
        dec.rt_val     = read_reg(rt);
        dec.imm        = {{(`XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};
        reads_rs       = 1'b1;
        reads_rt       = 1'b0;
        case (opcode)
            `OPC_RTYPE:
            begin
                reads_rt       = 1'b1;
                dec.dest       = rd;
                dec.writes_reg = 1'b1;
                case (funct)
                    `FN_ADD: dec.op = cpu_pkg::ADD;
                    `FN_SUB: dec.op = cpu_pkg::SUB;
                    `FN_AND: dec.op = cpu_pkg::AND;
                    `FN_OR:  dec.op = cpu_pkg::OR;
                    `FN_SLT: dec.op = cpu_pkg::SLT;
                    default: dec.exc = cpu_pkg::UNDEFINED;
                endcase
            end
            `OPC_ADDI:
            begin
                dec.op         = cpu_pkg::ADDI;
                dec.dest       = rt;
                dec.writes_reg = 1'b1;
            end
            `OPC_LW:
            begin
                dec.op         = cpu_pkg::LW;
                dec.dest       = rt;
                dec.writes_reg = 1'b1;
            end
            `OPC_SW:
            begin
                dec.op   = cpu_pkg::SW;
                reads_rt = 1'b1;
            end
            default: dec.exc = cpu_pkg::UNDEFINED;
        endcase
        if (if_id.instr == '0)      // all-zero word is a plain nop
        begin
            dec.op  = cpu_pkg::NOP;
            dec.exc = cpu_pkg::NONE;
        end
        if (dec.op == cpu_pkg::NOP || dec.exc != cpu_pkg::NONE)
        begin
            reads_rs       = 1'b0;
            reads_rt       = 1'b0;
            dec.writes_reg = 1'b0;
            dec.dest       = '0;
        end
        if (!if_id.valid)
            dec.exc = cpu_pkg::NONE;
        stall = if_id.valid && ((reads_rs && pending(rs)) || (reads_rt && pending(rt)));
    end

    assign id_ex_d = stall ? '0 : dec;  // bubble while waiting

    // writeback filters r0 before it reaches the file
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_we |-> wb_reg != '0);

endmodule

/* hw/execute_stage.sv */
// execute stage: decode/execute register, ALU and signed overflow detection
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                flush,
    input  cpu_pkg::id_ex_t     id_ex_d,
    output cpu_pkg::id_ex_t     id_ex_q,
    output cpu_pkg::ex_mem_t    ex_mem_d
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;
    logic             ovf;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex_q <= '0;
        else if (flush)
            id_ex_q <= '0;
        else
            id_ex_q <= id_ex_d;
    end

    assign a    = id_ex_q.rs_val;
    assign b    = (id_ex_q.op == cpu_pkg::ADDI || id_ex_q.op == cpu_pkg::LW ||
                   id_ex_q.op == cpu_pkg::SW) ? id_ex_q.imm : id_ex_q.rt_val;
    assign sum  = a + b;
    assign diff = a - b;

    always_comb
    begin
        ex_mem_d            = '0;
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.op         = id_ex_q.op;
        ex_mem_d.pc         = id_ex_q.pc;
        ex_mem_d.store_data = id_ex_q.rt_val;
        ex_mem_d.dest       = id_ex_q.dest;
        ex_mem_d.writes_reg = id_ex_q.writes_reg;
        ex_mem_d.exc        = id_ex_q.exc;
        ovf                 = 1'b0;
        case (id_ex_q.op)
            cpu_pkg::ADD, cpu_pkg::ADDI:
            begin
                ex_mem_d.result = sum;
                ovf = (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
            end
            cpu_pkg::SUB:
            begin
                ex_mem_d.result = diff;
                ovf = (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]);
            end
            cpu_pkg::AND: ex_mem_d.result = a & b;
            cpu_pkg::OR:  ex_mem_d.result = a | b;
            cpu_pkg::SLT: ex_mem_d.result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            cpu_pkg::LW, cpu_pkg::SW: ex_mem_d.result = sum;   // effective address
            default: ex_mem_d.result = '0;
        endcase
        if (id_ex_q.valid && ovf && id_ex_q.exc == cpu_pkg::NONE)  // earlier cause stays
            ex_mem_d.exc = cpu_pkg::OVERFLOW;
        if (ex_mem_d.exc != cpu_pkg::NONE)
            ex_mem_d.writes_reg = 1'b0;
    end

endmodule

/* hw/fetch_stage.sv */
// fetch stage: program counter, instruction request and the fetch/decode register
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  logic                flush,
    output logic [`XLEN-1:0]    imem_addr,
    input  logic [`XLEN-1:0]    imem_data,
    output cpu_pkg::if_id_t     if_id
);

    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;  // memory answers in the same cycle

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc    <= `RESET_PC;
            if_id <= '0;
        end
        else if (flush)                 // flush wins over stall
        begin
            pc    <= `EXC_VECTOR;
            if_id <= '0;
        end
        else if (!stall)
        begin
            pc          <= pc + `XLEN'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

    a_pc_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        pc[1:0] == 2'b00);

endmodule

/* hw/memory_stage.sv */
// memory stage: execute/memory register and word-addressed data memory for lw and sw
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage
(
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                flush,
    input  cpu_pkg::ex_mem_t    ex_mem_d,
    output cpu_pkg::ex_mem_t    ex_mem_q,
    output cpu_pkg::mem_wb_t    mem_wb_d
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
    logic [`XLEN-3:0]   word_addr;
    logic [IDX_W-1:0]   idx;
    logic               is_mem;
    logic               store_en;

    initial
    begin
        for (int i = 0; i < `DMEM_WORDS; i++)
            dmem[i] = '0;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem_q <= '0;
        else if (flush)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_mem_d;
    end

    assign word_addr = ex_mem_q.result[`XLEN-1:2];    // byte offset ignored
    assign idx       = word_addr[IDX_W-1:0];
    assign is_mem    = ex_mem_q.op == cpu_pkg::LW || ex_mem_q.op == cpu_pkg::SW;
    assign store_en  = ex_mem_q.valid && ex_mem_q.op == cpu_pkg::SW &&
                       ex_mem_q.exc == cpu_pkg::NONE && !flush;

    always_ff @(posedge SYS_clk)
    begin
        if (store_en)
            dmem[idx] <= ex_mem_q.store_data;
    end

    always_comb
    begin
        mem_wb_d.valid      = ex_mem_q.valid;
        mem_wb_d.pc         = ex_mem_q.pc;
        mem_wb_d.result     = (ex_mem_q.op == cpu_pkg::LW) ? dmem[idx] : ex_mem_q.result;
        mem_wb_d.dest       = ex_mem_q.dest;
        mem_wb_d.writes_reg = ex_mem_q.writes_reg;
        mem_wb_d.exc        = ex_mem_q.exc;
    end

    a_dmem_range: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (ex_mem_q.valid && is_mem && ex_mem_q.exc == cpu_pkg::NONE)
            |-> word_addr < `DMEM_WORDS);

endmodule

/* hw/writeback_stage.sv */
// writeback stage: memory/writeback register, register write, commit and exception report
`timescale 1ns/1ps
`include "cpu_settings.svh"

module writeback_stage
(
    input  logic                    SYS_clk,
    input  logic                    SYS_reset,
    input  cpu_pkg::mem_wb_t        mem_wb_d,
    output logic                    flush,
    output logic                    wb_we,
    output logic [`REG_ADDR_W-1:0]  wb_reg,
    output logic [`XLEN-1:0]        wb_data,
    output logic                    commit_valid,
    output logic [`REG_ADDR_W-1:0]  commit_reg,
    output logic [`XLEN-1:0]        commit_data,
    output logic                    exc_valid,
    output cpu_pkg::exc_cause_t     exc_cause,
    output logic [`XLEN-1:0]        epc
);

    cpu_pkg::mem_wb_t mem_wb_q;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_wb_q <= '0;
        else if (flush)
            mem_wb_q <= '0;     // faulting record leaves with the flush
        else
            mem_wb_q <= mem_wb_d;
    end

    assign flush = mem_wb_q.valid && mem_wb_q.exc != cpu_pkg::NONE;

    // excepting records never write, r0 writes are dropped here
    assign wb_we   = mem_wb_q.valid && mem_wb_q.writes_reg && mem_wb_q.dest != '0 &&
                     mem_wb_q.exc == cpu_pkg::NONE;
    assign wb_reg  = mem_wb_q.dest;
    assign wb_data = mem_wb_q.result;

    assign commit_valid = wb_we;
    assign commit_reg   = mem_wb_q.dest;
    assign commit_data  = mem_wb_q.result;

    assign exc_valid = flush;
    assign exc_cause = mem_wb_q.exc;
    assign epc       = mem_wb_q.pc;   // address of the faulting instruction

    a_exc_pulse: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |=> !exc_valid);

endmodule

/* list.f */
+incdir+hw
+incdir+tests
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/cpu_top.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build the cpu testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "run.sh: simulation ok"
    exit 0
fi
echo "run.sh: simulation reported errors"
exit 1

/* tests/cpu_program.svh */
// test program: main code at the reset PC and the exception handler at the vector
`ifndef CPU_PROGRAM_SVH
`define CPU_PROGRAM_SVH

localparam int MAIN_LEN    = 37;
localparam int HANDLER_LEN = 6;

localparam logic [31:0] MAIN_PROG [0:MAIN_LEN-1] = '{
    32'h2001_0007,  // addi r1, r0, 7
    32'h2002_fffd,  // addi r2, r0, -3
    32'h0022_1820,  // add  r3, r1, r2   dependent on r2
    32'h0022_2022,  // sub  r4, r1, r2
    32'h0064_2824,  // and  r5, r3, r4
    32'h0064_3025,  // or   r6, r3, r4
    32'h0041_382a,  // slt  r7, r2, r1
    32'h0022_402a,  // slt  r8, r1, r2
    32'h0021_0020,  // add  r0, r1, r1   dropped
    32'h0001_4825,  // or   r9, r0, r1
    32'hac03_0000,  // sw   r3, 0(r0)
    32'hac04_0004,  // sw   r4, 4(r0)
    32'h8c0a_0000,  // lw   r10, 0(r0)
    32'h014a_5820,  // add  r11, r10, r10   load use
    32'h8c0c_0004,  // lw   r12, 4(r0)
    32'hac06_0008,  // sw   r6, 8(r0)
    32'h2015_0055,  // addi r21, r0, 0x55
    32'h2016_0066,  // addi r22, r0, 0x66
    32'h2014_8000,  // addi r20, r0, -32768
    // add r20, r20, r20 sixteen times, ends at 0x80000000
    32'h0294_a020, 32'h0294_a020, 32'h0294_a020, 32'h0294_a020,
    32'h0294_a020, 32'h0294_a020, 32'h0294_a020, 32'h0294_a020,
    32'h0294_a020, 32'h0294_a020, 32'h0294_a020, 32'h0294_a020,
    32'h0294_a020, 32'h0294_a020, 32'h0294_a020, 32'h0294_a020,
    32'hfc00_0000,  // opcode 0x3f, undefined
    32'h200d_0001   // addi r13, r0, 1   never commits
};

// entered twice, the first pass overflows at the second addi
localparam logic [31:0] HANDLER_PROG [0:HANDLER_LEN-1] = '{
    32'h02a0_d025,  // or   r26, r21, r0   old r21
    32'h8c17_0008,  // lw   r23, 8(r0)
    32'h2294_0001,  // addi r20, r20, 1
    32'h2295_fffe,  // addi r21, r20, -2
    32'hac16_0008,  // sw   r22, 8(r0)
    32'h8c1b_0008   // lw   r27, 8(r0)
};

`endif

/* tests/cpu_tb.sv */
// cpu testbench: instruction memory, ISA reference model and commit/exception checks
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

    `include "cpu_program.svh"

    // one cycle plus up to three stalls per instruction, handler runs twice, doubled
    localparam int TIMEOUT_CYCLES = 2 * 4 * (MAIN_LEN + 2 * HANDLER_LEN);
    localparam int MAX_EXP        = 128;

    logic                       SYS_clk;
    logic                       SYS_reset;
    logic [`XLEN-1:0]           imem_addr;
    logic [`XLEN-1:0]           imem_data;
    logic                       commit_valid;
    logic [`REG_ADDR_W-1:0]     commit_reg;
    logic [`XLEN-1:0]           commit_data;
    logic                       exc_valid;
    cpu_pkg::exc_cause_t        exc_cause;
    logic [`XLEN-1:0]           epc;

    logic [`REG_ADDR_W-1:0]     exp_reg   [MAX_EXP];
    logic [`XLEN-1:0]           exp_data  [MAX_EXP];
    cpu_pkg::exc_cause_t        exp_cause [MAX_EXP];
    logic [`XLEN-1:0]           exp_epc   [MAX_EXP];
    int                         n_commits = 0;
    int                         n_excs = 0;
    int                         commit_ptr = 0;
    int                         exc_ptr = 0;
    int                         commit_errors = 0;
    int                         exc_errors = 0;
    int                         flow_errors = 0;
    int                         cycles = 0;
    logic                       timed_out = 1'b0;

    cpu_top cpu_top_i
    (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .commit_valid   (commit_valid),
        .commit_reg     (commit_reg),
        .commit_data    (commit_data),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .epc            (epc)
    );

    function automatic logic in_program(input logic [`XLEN-1:0] addr);
        return (addr - `RESET_PC) < 32'(4 * MAIN_LEN) ||
               (addr - `EXC_VECTOR) < 32'(4 * HANDLER_LEN);
    endfunction

    // zero outside both code regions, which decodes as a nop
    function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] main_off;
        logic [`XLEN-1:0] vec_off;
        main_off = addr - `RESET_PC;
        vec_off  = addr - `EXC_VECTOR;
        if (main_off < 32'(4 * MAIN_LEN))
            return MAIN_PROG[int'(main_off >> 2)];
        if (vec_off < 32'(4 * HANDLER_LEN))
            return HANDLER_PROG[int'(vec_off >> 2)];
        return '0;
    endfunction

    assign imem_data = fetch_word(imem_addr);   // combinational instruction memory

    // step the program one instruction at a time and record what must come out
    task automatic build_expected();
        logic [`XLEN-1:0]       regs [32];
        logic [`XLEN-1:0]       dmem [`DMEM_WORDS];
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       instr;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN:0]         wide;
        logic [`XLEN-1:0]       val;
        logic [`REG_ADDR_W-1:0] dst;
        logic                   wr;
        cpu_pkg::exc_cause_t    cause;
        int                     widx;
        int                     steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++)
            dmem[i] = '0;
        pc    = `RESET_PC;
        steps = 0;
        while (in_program(pc) && steps < 256)
        begin
            instr = fetch_word(pc);
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            imm   = {{16{instr[15]}}, instr[15:0]};
            wide  = {a[31], a} + {imm[31], imm};   // addi and address sum
            widx  = int'((wide[31:0] >> 2) % `DMEM_WORDS);
            val   = '0;
            dst   = instr[20:16];
            wr    = 1'b0;
            cause = cpu_pkg::NONE;
            if (instr != '0)
            begin
                case (instr[31:26])
                    `OPC_RTYPE:
                    begin
                        dst = instr[15:11];
                        wr  = 1'b1;
                        case (instr[5:0])
                            `FN_ADD: wide = {a[31], a} + {b[31], b};
                            `FN_SUB: wide = {a[31], a} - {b[31], b};
                            `FN_AND: wide = {1'b0, a & b};
                            `FN_OR:  wide = {1'b0, a | b};
                            `FN_SLT: wide = ($signed(a) < $signed(b)) ? 33'd1 : 33'd0;
                            default: cause = cpu_pkg::UNDEFINED;
                        endcase
                        val = wide[31:0];
                        if (instr[5:0] inside {`FN_ADD, `FN_SUB} && wide[32] != wide[31])
                            cause = cpu_pkg::OVERFLOW;
                    end
                    `OPC_ADDI:
                    begin
                        wr  = 1'b1;
                        val = wide[31:0];
                        if (wide[32] != wide[31])
                            cause = cpu_pkg::OVERFLOW;
                    end
                    `OPC_LW:
                    begin
                        wr  = 1'b1;
                        val = dmem[widx];
                    end
                    `OPC_SW:   dmem[widx] = b;
                    default:   cause = cpu_pkg::UNDEFINED;
                endcase
            end
            if (cause != cpu_pkg::NONE)
            begin
                exp_cause[n_excs] = cause;
                exp_epc[n_excs]   = pc;
                n_excs++;
                pc = `EXC_VECTOR;
            end
            else
            begin
                if (wr && dst != '0)    // r0 stays zero and never commits
                begin
                    regs[dst]           = val;
                    exp_reg[n_commits]  = dst;
                    exp_data[n_commits] = val;
                    n_commits++;
                end
                pc = pc + 32'd4;
            end
            steps++;
        end
    endtask

    always @(posedge SYS_clk)
    begin
        if (commit_valid)
            commit_ptr <= commit_ptr + 1;
        if (exc_valid)
            exc_ptr <= exc_ptr + 1;
    end

    a_commit_expected: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid |-> commit_ptr < n_commits)
    else
    begin
        commit_errors++;
        $display("unexpected commit to r%0d after all expected results", $sampled(commit_reg));
    end

    a_commit_reg: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid && commit_ptr < n_commits |-> commit_reg == exp_reg[commit_ptr])
    else
    begin
        commit_errors++;
        $display("FAIL commit_reg: got 0x%02h, expected 0x%02h",
                 $sampled(commit_reg), exp_reg[$sampled(commit_ptr)]);
    end

    a_commit_data: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit_valid && commit_ptr < n_commits |-> commit_data == exp_data[commit_ptr])
    else
    begin
        commit_errors++;
        $display("FAIL commit_data: got 0x%08h, expected 0x%08h",
                 $sampled(commit_data), exp_data[$sampled(commit_ptr)]);
    end

    a_exc_expected: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |-> exc_ptr < n_excs)
    else
    begin
        exc_errors++;
        $display("unexpected exception at pc 0x%08h", $sampled(epc));
    end

    a_exc_cause: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid && exc_ptr < n_excs |-> exc_cause == exp_cause[exc_ptr])
    else
    begin
        exc_errors++;
        $display("FAIL exc_cause: got 0x%0h, expected 0x%0h",
                 $sampled(exc_cause), exp_cause[$sampled(exc_ptr)]);
    end

    a_epc: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid && exc_ptr < n_excs |-> epc == exp_epc[exc_ptr])
    else
    begin
        exc_errors++;
        $display("FAIL epc: got 0x%08h, expected 0x%08h", $sampled(epc), exp_epc[$sampled(exc_ptr)]);
    end

    // fetch is redirected right after the pulse
    a_vector_next: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        exc_valid |=> imem_addr == `EXC_VECTOR)
    else
    begin
        flow_errors++;
        $display("FAIL imem_addr: got 0x%08h, expected 0x%08h", $sampled(imem_addr), `EXC_VECTOR);
    end

    a_reset_state: assert property (@(posedge SYS_clk)
        $fell(SYS_reset) |-> imem_addr == `RESET_PC && !commit_valid && !exc_valid)
    else
    begin
        flow_errors++;
        $display("pipeline not in its reset state when reset was released");
    end

    initial
    begin
        SYS_clk = 1'b0;
        forever #5 SYS_clk = ~SYS_clk;
    end

    initial
    begin
        SYS_reset = 1'b1;
        build_expected();
        repeat (10) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        while (!(commit_ptr == n_commits && exc_ptr == n_excs) && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge SYS_clk);
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES)
        begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles with %0d of %0d commits and %0d of %0d exceptions",
                     cycles, commit_ptr, n_commits, exc_ptr, n_excs);
        end
        else
        begin
            repeat (20) @(posedge SYS_clk);   // extra commits or exceptions show up here
        end
        $display("error counts: commit %0d, exception %0d, control flow %0d, timeout %0d",
                 commit_errors, exc_errors, flow_errors, timed_out);
        if (commit_errors == 0 && exc_errors == 0 && flow_errors == 0 && !timed_out)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
